// ==== flist.f ====
+incdir+source
source/dcache_pkg.sv
source/dcache_array.sv
source/store_buffer.sv
source/dcache_top.sv
dv/tb_mem_model.sv
dv/tb_dcache.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the dcache testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    -f flist.f --top-module tb_dcache -Mdir obj_dir -o tb_dcache > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status, see build.log"
    exit 1
fi

./obj_dir/tb_dcache > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation run exited with status $status, see sim.log"
    exit 1
fi

# The log decides the result
if grep -q "^Simulation passed$" sim.log; then
    echo "PASS: see sim.log"
    exit 0
fi
echo "FAIL: see sim.log"
exit 1

// ==== dv/tb_dcache.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module tb_dcache;

    import dcache_pkg::*;

    localparam int TIMEOUT = 200;

    logic        clk;
    logic        rst;
    logic        req_valid;
    cpu_req_t    req;
    logic        req_ready;
    logic [31:0] load_data;
    logic        mem_req_valid;
    logic        mem_req_ready;
    mem_req_t    mem_req;
    mem_res_t    mem_res;
    mem_wb_t     mem_wb;

    int           req_count;
    int           res_count;
    int           wb_count;
    int           addr_errors;
    logic [31:0]  last_req_addr;
    logic [31:0]  last_wb_addr;
    logic [127:0] last_wb_data;

    // Expected memory, stores applied in acceptance order
    logic [31:0] ref_img [256];

    int test_errors;
    int total_errors;
    int tests_run;
    int tests_failed;

    dcache_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .load_data     (load_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_res       (mem_res),
        .mem_wb        (mem_wb)
    );

    tb_mem_model i_mem (
        .clk           (clk),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_res       (mem_res),
        .mem_wb        (mem_wb),
        .req_count     (req_count),
        .res_count     (res_count),
        .wb_count      (wb_count),
        .addr_errors   (addr_errors),
        .last_req_addr (last_req_addr),
        .last_wb_addr  (last_wb_addr),
        .last_wb_data  (last_wb_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got == exp) else begin
            $display("Mismatch %s: got %0h, expected %0h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("%s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "FAILED", test_errors);
        test_errors = 0;
    endtask

    // Byte lanes are little endian within a word
    function automatic logic [31:0] expected_load(logic [31:0] addr, logic [1:0] size);
        logic [31:0] word;
        logic [7:0]  b;
        word = ref_img[addr[9:2]];
        b    = word[{addr[1:0], 3'b000} +: 8];
        if (size == `DC_SIZE_BYTE) begin
            return {{24{b[7]}}, b};
        end
        return word;
    endfunction

    function automatic void apply_store(logic [31:0] addr, logic [1:0] size, logic [31:0] value);
        if (size == `DC_SIZE_BYTE) begin
            ref_img[addr[9:2]][{addr[1:0], 3'b000} +: 8] = value[7:0];
        end else begin
            ref_img[addr[9:2]] = value;
        end
    endfunction

    function automatic logic [127:0] ref_line(logic [31:0] addr);
        logic [127:0] line;
        for (int w = 0; w < 4; w++) begin
            line[32*w +: 32] = ref_img[{addr[9:4], 2'(w)}];
        end
        return line;
    endfunction

    // Hold one request until it completes, called 1 ns after a rising edge
    task automatic access(input logic [31:0] addr, input logic store, input logic [1:0] size,
                          input logic [31:0] wdata, output int cycles, output logic [31:0] data);
        logic done;
        done      = 1'b0;
        cycles    = 0;
        data      = '0;
        req_valid = 1'b1;
        req       = '{addr: addr, store: store, size: size, wdata: wdata};
        while (!done && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (req_ready) begin
                done = 1'b1;
                data = load_data;
            end
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
        assert (done) else begin
            $display("Error: access to %h was not accepted within %0d cycles", addr, TIMEOUT);
            test_errors++;
        end
        if (done && store) begin
            apply_store(addr, size, wdata);
        end
    endtask

    task automatic store_to(input logic [31:0] addr, input logic [1:0] size,
                            input logic [31:0] value, output int cycles);
        logic [31:0] unused;
        access(addr, 1'b1, size, value, cycles, unused);
    endtask

    task automatic load_and_compare(input logic [31:0] addr, input logic [1:0] size,
                                    output int cycles);
        logic [31:0] data;
        access(addr, 1'b0, size, '0, cycles, data);
        check_value("load_data", data, expected_load(addr, size));
    endtask

    task automatic cold_load_miss();
        int cycles;
        int reqs_before;
        // Idle after reset
        @(negedge clk);
        check_value("mem_req_valid", mem_req_valid, 0);
        check_value("mem_wb.valid", mem_wb.valid, 0);
        @(posedge clk);
        #1;
        reqs_before = req_count;
        load_and_compare(32'h14, `DC_SIZE_WORD, cycles);
        check_value("refill count", req_count - reqs_before, 1);
        check_value("mem_req.addr", last_req_addr, 32'h10);
        // Same line now hits
        load_and_compare(32'h18, `DC_SIZE_WORD, cycles);
        check_value("hit accept cycles", cycles, 1);
        report_test("cold load miss");
    endtask

    task automatic byte_loads();
        int cycles;
        load_and_compare(32'h10, `DC_SIZE_BYTE, cycles);
        load_and_compare(32'h13, `DC_SIZE_BYTE, cycles);
        load_and_compare(32'h17, `DC_SIZE_BYTE, cycles);
        load_and_compare(32'h1e, `DC_SIZE_BYTE, cycles);
        // Byte load that misses first
        load_and_compare(32'h2b, `DC_SIZE_BYTE, cycles);
        report_test("byte load");
    endtask

    task automatic store_then_load();
        int cycles;
        store_to(32'h14, `DC_SIZE_WORD, 32'h8000_1234, cycles);
        check_value("store accept cycles", cycles, 1);
        load_and_compare(32'h14, `DC_SIZE_WORD, cycles);
        store_to(32'h19, `DC_SIZE_BYTE, 32'h0000_00a5, cycles);
        check_value("store accept cycles", cycles, 1);
        // Neighbour bytes of the word keep their old value
        load_and_compare(32'h18, `DC_SIZE_WORD, cycles);
        load_and_compare(32'h19, `DC_SIZE_BYTE, cycles);
        report_test("store then load");
    endtask

    task automatic store_under_miss();
        int cycles;
        int res_before;
        res_before = res_count;
        store_to(32'h34, `DC_SIZE_WORD, 32'hcafe_0034, cycles);
        check_value("store accept cycles", cycles, 1);
        store_to(32'h3a, `DC_SIZE_BYTE, 32'h0000_007e, cycles);
        check_value("store accept cycles", cycles, 1);
        check_value("mem_res count", res_count - res_before, 0);
        // Merged after the refill installs
        load_and_compare(32'h34, `DC_SIZE_WORD, cycles);
        load_and_compare(32'h38, `DC_SIZE_WORD, cycles);
        load_and_compare(32'h3c, `DC_SIZE_WORD, cycles);
        report_test("store under miss");
    endtask

    task automatic dirty_eviction();
        int           cycles;
        int           wb_before;
        logic [127:0] old_line;
        // Set 1 holds the dirty tag 0 line
        wb_before = wb_count;
        old_line  = ref_line(32'h10);
        load_and_compare(32'h114, `DC_SIZE_WORD, cycles);
        check_value("write-back count", wb_count - wb_before, 1);
        check_value("mem_wb.addr", last_wb_addr, 32'h10);
        check_value("mem_wb.data", last_wb_data, old_line);
        // Set 2 line is clean
        wb_before = wb_count;
        load_and_compare(32'h224, `DC_SIZE_WORD, cycles);
        check_value("write-back count", wb_count - wb_before, 0);
        // Written-back stores come back from memory
        load_and_compare(32'h14, `DC_SIZE_WORD, cycles);
        report_test("dirty eviction");
    endtask

    task automatic back_pressure();
        int cycles;
        mem_req_ready = 1'b0;
        req_valid     = 1'b1;
        req           = '{addr: 32'h58, store: 1'b0, size: `DC_SIZE_WORD, wdata: '0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_value("mem_req_valid", mem_req_valid, 1);
            check_value("mem_req.addr", mem_req.addr, 32'h50);
            check_value("req_ready", req_ready, 0);
            @(posedge clk);
            #1;
        end
        mem_req_ready = 1'b1;
        load_and_compare(32'h58, `DC_SIZE_WORD, cycles);
        // Stores under the set 6 refill fill the buffer before the head can drain
        for (int i = 0; i < `DC_SB_ENTRIES; i++) begin
            store_to(32'h60 + 4 * i, `DC_SIZE_WORD, 32'h6000_0000 + i, cycles);
            check_value("store accept cycles", cycles, 1);
        end
        store_to(32'h60, `DC_SIZE_WORD, 32'h6666_6666, cycles);
        assert (cycles > 1) else begin
            $display("Error: store was accepted while the store buffer was full");
            test_errors++;
        end
        for (int i = 0; i < `DC_SB_ENTRIES; i++) begin
            load_and_compare(32'h60 + 4 * i, `DC_SIZE_WORD, cycles);
        end
        report_test("back-pressure");
    endtask

    initial begin
        rst           = 1'b1;
        req_valid     = 1'b0;
        req           = '0;
        mem_req_ready = 1'b1;
        test_errors   = 0;
        total_errors  = 0;
        tests_run     = 0;
        tests_failed  = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        // Expected image starts from the memory contents
        for (int i = 0; i < 256; i++) begin
            ref_img[i] = i_mem.image[i];
        end
        cold_load_miss();
        byte_loads();
        store_then_load();
        store_under_miss();
        dirty_eviction();
        back_pressure();
        assert (addr_errors == 0) else begin
            $display("Error: memory model saw %0d refills outside its image", addr_errors);
            total_errors++;
        end
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== dv/tb_mem_model.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module tb_mem_model (
    input  logic                  clk,
    input  logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    input  dcache_pkg::mem_req_t  mem_req,
    output dcache_pkg::mem_res_t  mem_res,
    input  dcache_pkg::mem_wb_t   mem_wb,
    output int                    req_count,
    output int                    res_count,
    output int                    wb_count,
    output int                    addr_errors,
    output logic [31:0]           last_req_addr,
    output logic [31:0]           last_wb_addr,
    output logic [127:0]          last_wb_data
);

    import dcache_pkg::*;

    localparam int LATENCY = 4;

    // 64 lines of backing store, addresses 0x000 to 0x3ff
    logic [31:0] image [256];

    // Refills in issue order with the cycle each answer is driven
    logic [31:0] pend_addr [$];
    int          pend_due  [$];

    int          seed;
    int          cyc;
    logic        fire;
    logic [31:0] fire_addr;
    mem_wb_t     wb;
    logic [31:0] res_addr;

    function automatic logic [127:0] read_line(logic [31:0] addr);
        logic [127:0] line;
        for (int w = 0; w < 4; w++) begin
            line[32*w +: 32] = image[{addr[9:4], 2'(w)}];
        end
        return line;
    endfunction

    initial begin
        seed = 32'hf197d45b;
        for (int i = 0; i < 256; i++) begin
            image[i] = $random(seed);
        end
        mem_res     = '0;
        req_count   = 0;
        res_count   = 0;
        wb_count    = 0;
        addr_errors = 0;
        cyc         = 0;
        forever begin
            // Sample mid-cycle, where the DUT outputs are settled
            @(negedge clk);
            fire      = mem_req_valid && mem_req_ready;
            fire_addr = mem_req.addr;
            wb        = mem_wb;
            @(posedge clk);
            #1;
            cyc++;
            // Write-back is always taken
            if (wb.valid) begin
                for (int w = 0; w < 4; w++) begin
                    image[{wb.addr[9:4], 2'(w)}] = wb.data[32*w +: 32];
                end
                wb_count++;
                last_wb_addr = wb.addr;
                last_wb_data = wb.data;
            end
            if (fire) begin
                req_count++;
                last_req_addr = fire_addr;
                if (fire_addr[31:10] != '0) begin
                    addr_errors++;
                end
                pend_addr.push_back(fire_addr);
                pend_due.push_back(cyc + LATENCY - 1);
            end
            // Answer lands on the fourth edge after the accepting one
            mem_res = '0;
            if (pend_due.size() > 0 && pend_due[0] == cyc) begin
                res_addr      = pend_addr.pop_front();
                void'(pend_due.pop_front());
                mem_res.valid = 1'b1;
                mem_res.addr  = res_addr;
                mem_res.data  = read_line(res_addr);
                res_count++;
            end
        end
    end

endmodule

// ==== source/dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  dcache_pkg::cpu_req_t     req,
    output logic                     req_ready,
    output logic [`DC_WORD_BITS-1:0] load_data,
    output logic                     mem_req_valid,
    input  logic                     mem_req_ready,
    output dcache_pkg::mem_req_t     mem_req,
    input  dcache_pkg::mem_res_t     mem_res,
    output dcache_pkg::mem_wb_t      mem_wb
);

    import dcache_pkg::*;

    sb_entry_t sb_head;
    sb_entry_t push_entry;

    logic hit;
    logic store_ok;
    logic sb_full;
    logic sb_valid;
    logic sb_done;
    logic probe_hazard;
    logic array_valid;
    logic push;

    // A store facing a full buffer is a bubble for the array
    // so it neither issues a refill nor counts a pin
    assign array_valid = req_valid && !(req.store && sb_full);

    // Loads wait on a miss or an older store to the same word
    assign req_ready = req.store ? (store_ok && !sb_full) : (hit && !probe_hazard);

    // Accepted store enters the buffer on the same edge
    assign push       = req_valid && req_ready && req.store;
    assign push_entry = '{addr: req.addr, value: req.wdata, size: req.size};

    dcache_array i_array (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (array_valid),
        .req           (req),
        .hit           (hit),
        .load_data     (load_data),
        .store_ok      (store_ok),
        .sb_valid      (sb_valid),
        .sb_head       (sb_head),
        .sb_done       (sb_done),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_res       (mem_res),
        .mem_wb        (mem_wb)
    );

    store_buffer i_store_buffer (
        .clk          (clk),
        .rst          (rst),
        .push         (push),
        .push_entry   (push_entry),
        .full         (sb_full),
        .sb_valid     (sb_valid),
        .sb_head      (sb_head),
        .sb_done      (sb_done),
        .probe_addr   (req.addr),
        .probe_hazard (probe_hazard)
    );

endmodule

// ==== source/store_buffer.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module store_buffer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push,
    input  dcache_pkg::sb_entry_t    push_entry,
    output logic                     full,
    output logic                     sb_valid,
    output dcache_pkg::sb_entry_t    sb_head,
    input  logic                     sb_done,
    input  logic [`DC_WORD_BITS-1:0] probe_addr,
    output logic                     probe_hazard
);

    import dcache_pkg::*;

    localparam int PTR_BITS = $clog2(`DC_SB_ENTRIES);
    localparam int CNT_BITS = PTR_BITS + 1;

    // Circular storage, oldest entry at rd_ptr
    sb_entry_t entries [`DC_SB_ENTRIES];

    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [CNT_BITS-1:0] count;

    logic do_push;
    logic do_pop;

    // Per-entry occupancy and word match against the probe
    logic [`DC_SB_ENTRIES-1:0] occupied;
    logic [`DC_SB_ENTRIES-1:0] word_match;

    assign full     = (count == CNT_BITS'(`DC_SB_ENTRIES));
    assign sb_valid = (count != '0);
    assign sb_head  = entries[rd_ptr];

    // Full blocks a push, empty blocks a pop
    assign do_push = push && !full;
    assign do_pop  = sb_done && sb_valid;

    // An entry is live if its distance from the head is below the count
    always_comb begin
        logic [PTR_BITS-1:0] age;
        for (int i = 0; i < `DC_SB_ENTRIES; i++) begin
            age           = PTR_BITS'(i) - rd_ptr;
            occupied[i]   = {1'b0, age} < count;
            // Word granularity, byte lanes ignored
            word_match[i] = entries[i].addr[`DC_WORD_BITS-1:2] ==
                            probe_addr[`DC_WORD_BITS-1:2];
        end
    end

    // Any live older store to the probed word
    assign probe_hazard = |(occupied & word_match);

    // Pointers and count
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the count unchanged
            count <= count + CNT_BITS'(do_push) - CNT_BITS'(do_pop);
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

endmodule

// ==== source/dcache_array.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_array (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  dcache_pkg::cpu_req_t     req,
    output logic                     hit,
    output logic [`DC_WORD_BITS-1:0] load_data,
    output logic                     store_ok,
    input  logic                     sb_valid,
    input  dcache_pkg::sb_entry_t    sb_head,
    output logic                     sb_done,
    output logic                     mem_req_valid,
    input  logic                     mem_req_ready,
    output dcache_pkg::mem_req_t     mem_req,
    input  dcache_pkg::mem_res_t     mem_res,
    output dcache_pkg::mem_wb_t      mem_wb
);

    // Per-set line state
    logic [`DC_N_LINES-1:0]   line_valid;
    logic [`DC_N_LINES-1:0]   dirty;
    logic [`DC_TAG_BITS-1:0]  tags  [`DC_N_LINES];
    logic [`DC_LINE_BITS-1:0] lines [`DC_N_LINES];
    logic [`DC_PIN_BITS-1:0]  pins  [`DC_N_LINES];

    // Outstanding refill record, one per set
    // Pins gathered here move to the line on install
    logic [`DC_N_LINES-1:0]   mrq_present;
    logic [`DC_TAG_BITS-1:0]  mrq_tag  [`DC_N_LINES];
    logic [`DC_PIN_BITS-1:0]  mrq_pins [`DC_N_LINES];

    // Pipeline address split
    logic [`DC_OFFSET_BITS-1:0] offset;
    logic [`DC_SET_BITS-1:0]    set;
    logic [`DC_TAG_BITS-1:0]    tag;

    // Store buffer head address split
    logic [`DC_OFFSET_BITS-1:0] sb_offset;
    logic [`DC_SET_BITS-1:0]    sb_set;
    logic [`DC_TAG_BITS-1:0]    sb_tag;

    // Refill response address split
    logic [`DC_SET_BITS-1:0]    res_set;
    logic [`DC_TAG_BITS-1:0]    res_tag;

    // One-hot set selects for the per-set update loop
    logic [`DC_N_LINES-1:0] req_sel;
    logic [`DC_N_LINES-1:0] sb_sel;
    logic [`DC_N_LINES-1:0] res_sel;

    logic refill_fire;
    logic install;
    logic pin_inc_line;
    logic pin_inc_mrq;

    logic [`DC_LINE_BITS-1:0] line_read;
    logic [`DC_LINE_BITS-1:0] line_merged;
    logic [7:0]               load_byte;
    logic [`DC_WORD_BITS-1:0] load_word;

    assign offset    = req.addr[`DC_OFFSET_BITS-1:0];
    assign set       = req.addr[`DC_OFFSET_BITS +: `DC_SET_BITS];
    assign tag       = req.addr[`DC_WORD_BITS-1 -: `DC_TAG_BITS];

    assign sb_offset = sb_head.addr[`DC_OFFSET_BITS-1:0];
    assign sb_set    = sb_head.addr[`DC_OFFSET_BITS +: `DC_SET_BITS];
    assign sb_tag    = sb_head.addr[`DC_WORD_BITS-1 -: `DC_TAG_BITS];

    assign res_set   = mem_res.addr[`DC_OFFSET_BITS +: `DC_SET_BITS];
    assign res_tag   = mem_res.addr[`DC_WORD_BITS-1 -: `DC_TAG_BITS];

    assign req_sel   = `DC_N_LINES'(1) << set;
    assign sb_sel    = `DC_N_LINES'(1) << sb_set;
    assign res_sel   = `DC_N_LINES'(1) << res_set;

    // Hit needs a valid line with a matching tag
    assign hit = line_valid[set] && (tags[set] == tag);

    // Refill only for an idle, unpinned set
    assign mem_req_valid = req_valid && !hit && (pins[set] == '0) && !mrq_present[set];
    assign mem_req.addr  = {tag, set, {`DC_OFFSET_BITS{1'b0}}};
    assign refill_fire   = mem_req_valid && mem_req_ready;

    // Store may go in when it hits, when the pending refill is its own line,
    // or when its refill is being issued right now
    // A hit with a refill pending for another tag waits, the line is about to go
    assign store_ok = mrq_present[set] ? (mrq_tag[set] == tag) : (hit || refill_fire);

    // Where the pin of an accepted store is counted
    assign pin_inc_line = req_valid && req.store && store_ok && hit;
    assign pin_inc_mrq  = req_valid && req.store && store_ok && !hit;

    // Response only installs against a matching record
    assign install = mem_res.valid && mrq_present[res_set] && (mrq_tag[res_set] == res_tag);

    // Dirty victim leaves in the install cycle
    assign mem_wb.valid = install && line_valid[res_set] && dirty[res_set];
    assign mem_wb.addr  = {tags[res_set], res_set, {`DC_OFFSET_BITS{1'b0}}};
    assign mem_wb.data  = lines[res_set];

    // Head drains once its line is present
    assign sb_done = sb_valid && line_valid[sb_set] && (tags[sb_set] == sb_tag);

    // Load extraction, word loads are aligned
    assign line_read = lines[set];
    assign load_byte = line_read[{offset, 3'b000} +: 8];
    assign load_word = line_read[{offset[`DC_OFFSET_BITS-1:2], 5'b00000} +: `DC_WORD_BITS];

    always_comb begin
        case (req.size)
            // LB sign extends
            `DC_SIZE_BYTE: load_data = {{(`DC_WORD_BITS - 8){load_byte[7]}}, load_byte};
            default:       load_data = load_word;
        endcase
    end

    // Merge the head store into a copy of its line
    always_comb begin
        line_merged = lines[sb_set];
        case (sb_head.size)
            `DC_SIZE_BYTE: begin
                line_merged[{sb_offset, 3'b000} +: 8] = sb_head.value[7:0];
            end
            default: begin
                line_merged[{sb_offset[`DC_OFFSET_BITS-1:2], 5'b00000} +: `DC_WORD_BITS] =
                    sb_head.value;
            end
        endcase
    end

    // Control state per set
    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid  <= '0;
            dirty       <= '0;
            mrq_present <= '0;
            for (int s = 0; s < `DC_N_LINES; s++) begin
                pins[s]     <= '0;
                mrq_pins[s] <= '0;
            end
        end else begin
            for (int s = 0; s < `DC_N_LINES; s++) begin
                // Install replaces the line, which inherits the record's pins
                // Drain to the same set cannot happen, the new line is not present yet
                if (install && res_sel[s]) begin
                    line_valid[s] <= 1'b1;
                    dirty[s]      <= 1'b0;
                    pins[s]       <= mrq_pins[s] + `DC_PIN_BITS'(pin_inc_mrq && req_sel[s]);
                end else begin
                    // Store hit and drain can meet on one set
                    pins[s] <= pins[s] + `DC_PIN_BITS'(pin_inc_line && req_sel[s])
                                       - `DC_PIN_BITS'(sb_done && sb_sel[s]);
                    if (sb_done && sb_sel[s]) begin
                        dirty[s] <= 1'b1;
                    end
                end

                // Refill record; issue and install never share a set
                if (refill_fire && req_sel[s]) begin
                    mrq_present[s] <= 1'b1;
                    mrq_pins[s]    <= `DC_PIN_BITS'(pin_inc_mrq);
                end else if (install && res_sel[s]) begin
                    mrq_present[s] <= 1'b0;
                    mrq_pins[s]    <= '0;
                end else if (pin_inc_mrq && req_sel[s]) begin
                    mrq_pins[s]    <= mrq_pins[s] + 1'b1;
                end
            end
        end
    end

    // Tags, line data and record tags
    always_ff @(posedge clk) begin
        if (refill_fire) begin
            mrq_tag[set] <= tag;
        end
        if (install) begin
            tags[res_set]  <= res_tag;
            lines[res_set] <= mem_res.data;
        end
        // Head write lands on a present line
        if (sb_done) begin
            lines[sb_set] <= line_merged;
        end
    end

endmodule

// ==== source/dcache_pkg.sv ====
`include "dcache_defines.svh"

package dcache_pkg;

    // Refill request, qualified by a separate valid
    // Address is line aligned
    typedef struct packed {
        logic [`DC_WORD_BITS-1:0] addr;
    } mem_req_t;

    // Refill response from memory, no handshake
    typedef struct packed {
        logic                     valid;
        logic [`DC_WORD_BITS-1:0] addr;
        logic [`DC_LINE_BITS-1:0] data;
    } mem_res_t;

    // Dirty victim going back to memory
    // Valid for a single cycle, always accepted
    typedef struct packed {
        logic                     valid;
        logic [`DC_WORD_BITS-1:0] addr;
        logic [`DC_LINE_BITS-1:0] data;
    } mem_wb_t;

    // One buffered store waiting to reach its line
    typedef struct packed {
        logic [`DC_WORD_BITS-1:0] addr;
        logic [`DC_WORD_BITS-1:0] value;
        logic [1:0]               size;
    } sb_entry_t;

    // Pipeline access, load or store
    // Store value is ignored for loads
    typedef struct packed {
        logic [`DC_WORD_BITS-1:0] addr;
        logic                     store;
        logic [1:0]               size;
        logic [`DC_WORD_BITS-1:0] wdata;
    } cpu_req_t;

endpackage

// ==== source/dcache_defines.svh ====
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Word width for addresses and load/store data
`define DC_WORD_BITS 32

// Line geometry
`define DC_LINE_BYTES 16
`define DC_LINE_BITS (`DC_LINE_BYTES * 8)
`define DC_N_LINES 16

// Address split, direct mapped
// Tag [31:8], set [7:4], byte offset [3:0]
`define DC_OFFSET_BITS 4
`define DC_SET_BITS 4
`define DC_TAG_BITS 24

// Store buffer depth
`define DC_SB_ENTRIES 4

// Pin counter must reach the store buffer depth
`define DC_PIN_BITS 3

// Access size codes
`define DC_SIZE_BYTE 2'b00
`define DC_SIZE_WORD 2'b10

`endif
